/* Bender.yml */
package:
  name: modexp

sources:
  - files:
      - hw/modexp_pkg.sv
      - hw/operand_loader.sv
      - hw/mont_const_gen.sv
      - hw/mont_mul.sv
      - hw/modexp_sequencer.sv
      - hw/result_serializer.sv
      - hw/modexp_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_modexp.sv

/* hw/modexp_pkg.sv */
`default_nettype none

package modexp_pkg;

    // ---------------------------------------------------------------------
    // default operand geometry
    // ---------------------------------------------------------------------
    // bits per word
    localparam int default_word_w    = 32;
    // words per operand
    localparam int default_num_words = 4;

    // ---------------------------------------------------------------------
    // sequencer states and multiplier operand selects
    // ---------------------------------------------------------------------
    typedef enum logic [2:0] {
        idle,
        const_wait,
        to_mont,
        square,
        multiply,
        from_mont,
        emit
    } seq_state_e;

    typedef enum logic [1:0] {
        op_to_mont,
        op_square,
        op_mult,
        op_from_mont
    } mont_op_e;

endpackage

`default_nettype wire

/* hw/modexp_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module modexp_sequencer #(
    parameter int K = modexp_pkg::default_word_w,
    parameter int N = modexp_pkg::default_num_words
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             operands_ready,
    input  logic [K*N-1:0]   x_full,
    input  logic [K*N-1:0]   y_full,
    input  logic             const_done,
    input  logic [K*N-1:0]   r_mod_m,
    input  logic [K*N-1:0]   r2_mod_m,
    input  logic             mul_done,
    input  logic [K*N-1:0]   mul_p,
    output logic             const_start,
    output logic             mul_start,
    output logic [K*N-1:0]   mul_a,
    output logic [K*N-1:0]   mul_b,
    output logic             res_load,
    output logic [K*N-1:0]   res_full
);

    import modexp_pkg::*;

    localparam int W  = K * N;
    localparam int BW = $clog2(W);

    seq_state_e    state_q;
    mont_op_e      op_q;
    logic [BW-1:0] bit_q;
    // running result and x, both in montgomery form
    logic [W-1:0]  acc_q;
    logic [W-1:0]  xm_q;
    logic          y_bit;
    logic          last_bit;

    assign y_bit    = y_full[bit_q];
    assign last_bit = (bit_q == '0);
    assign res_load = (state_q == emit);

    // operand pair for the multiplier
    always_comb begin
        case (op_q)
            op_to_mont: begin
                mul_a = x_full;
                mul_b = r2_mod_m;
            end
            op_square: begin
                mul_a = acc_q;
                mul_b = acc_q;
            end
            op_mult: begin
                mul_a = acc_q;
                mul_b = xm_q;
            end
            default: begin
                mul_a = acc_q;
                mul_b = W'(1);
            end
        endcase
    end

    // ---------------------------------------------------------------------
    // square-and-multiply control
    // ---------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= idle;
            op_q        <= op_to_mont;
            bit_q       <= '0;
            const_start <= 1'b0;
            mul_start   <= 1'b0;
        end else begin
            const_start <= 1'b0;
            mul_start   <= 1'b0;
            case (state_q)
                idle: begin
                    if (operands_ready) begin
                        const_start <= 1'b1;
                        state_q     <= const_wait;
                    end
                end
                const_wait: begin
                    if (const_done) begin
                        op_q      <= op_to_mont;
                        mul_start <= 1'b1;
                        state_q   <= to_mont;
                    end
                end
                to_mont: begin
                    if (mul_done) begin
                        bit_q     <= BW'(W - 1);
                        op_q      <= op_square;
                        mul_start <= 1'b1;
                        state_q   <= square;
                    end
                end
                square: begin
                    if (mul_done) begin
                        mul_start <= 1'b1;
                        if (y_bit) begin
                            op_q    <= op_mult;
                            state_q <= multiply;
                        end else if (last_bit) begin
                            op_q    <= op_from_mont;
                            state_q <= from_mont;
                        end else begin
                            bit_q <= bit_q - 1'b1;
                        end
                    end
                end
                multiply: begin
                    if (mul_done) begin
                        mul_start <= 1'b1;
                        if (last_bit) begin
                            op_q    <= op_from_mont;
                            state_q <= from_mont;
                        end else begin
                            bit_q   <= bit_q - 1'b1;
                            op_q    <= op_square;
                            state_q <= square;
                        end
                    end
                end
                from_mont: begin
                    if (mul_done) begin
                        state_q <= emit;
                    end
                end
                emit: begin
                    state_q <= idle;
                end
                default: begin
                    state_q <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // acc starts as 1 in montgomery form
        if (state_q == const_wait && const_done) begin
            acc_q <= r_mod_m;
        end
        if (mul_done && (state_q == square || state_q == multiply)) begin
            acc_q <= mul_p;
        end
        if (mul_done && state_q == to_mont) begin
            xm_q <= mul_p;
        end
        if (mul_done && state_q == from_mont) begin
            res_full <= mul_p;
        end
    end

    done_when_waiting: assert property (@(posedge clk) disable iff (!rst_n)
        mul_done |-> state_q inside {to_mont, square, multiply, from_mont})
        else $error("modexp_sequencer: mul_done outside a multiply step");

endmodule

`default_nettype wire

/* hw/modexp_top.sv */
`timescale 1ns/1ps
`default_nettype none

module modexp_top #(
    parameter int K = modexp_pkg::default_word_w,
    parameter int N = modexp_pkg::default_num_words
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           me_start,
    input  logic [K-1:0]   me_x,
    input  logic           me_x_valid,
    input  logic [K-1:0]   me_y,
    input  logic           me_y_valid,
    input  logic [K-1:0]   me_m,
    input  logic           me_m_valid,
    output logic [K-1:0]   me_result,
    output logic           me_valid
);

    localparam int W = K * N;

    logic [W-1:0] x_full;
    logic [W-1:0] y_full;
    logic [W-1:0] m_full;
    logic         operands_ready;
    logic         const_start;
    logic         const_done;
    logic [W-1:0] r_mod_m;
    logic [W-1:0] r2_mod_m;
    logic         mul_start;
    logic         mul_done;
    logic [W-1:0] mul_a;
    logic [W-1:0] mul_b;
    logic [W-1:0] mul_p;
    logic         res_load;
    logic [W-1:0] res_full;

    // ---------------------------------------------------------------------
    // input side
    // ---------------------------------------------------------------------
    operand_loader #(.K(K), .N(N)) loader0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .me_start       (me_start),
        .me_x           (me_x),
        .me_x_valid     (me_x_valid),
        .me_y           (me_y),
        .me_y_valid     (me_y_valid),
        .me_m           (me_m),
        .me_m_valid     (me_m_valid),
        .x_full         (x_full),
        .y_full         (y_full),
        .m_full         (m_full),
        .operands_ready (operands_ready)
    );

    // ---------------------------------------------------------------------
    // processing
    // ---------------------------------------------------------------------
    mont_const_gen #(.K(K), .N(N)) const0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .const_start (const_start),
        .m_full      (m_full),
        .const_done  (const_done),
        .r_mod_m     (r_mod_m),
        .r2_mod_m    (r2_mod_m)
    );

    mont_mul #(.K(K), .N(N)) mul0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .mul_start (mul_start),
        .mul_a     (mul_a),
        .mul_b     (mul_b),
        .m_full    (m_full),
        .mul_done  (mul_done),
        .mul_p     (mul_p)
    );

    modexp_sequencer #(.K(K), .N(N)) seq0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .operands_ready (operands_ready),
        .x_full         (x_full),
        .y_full         (y_full),
        .const_done     (const_done),
        .r_mod_m        (r_mod_m),
        .r2_mod_m       (r2_mod_m),
        .mul_done       (mul_done),
        .mul_p          (mul_p),
        .const_start    (const_start),
        .mul_start      (mul_start),
        .mul_a          (mul_a),
        .mul_b          (mul_b),
        .res_load       (res_load),
        .res_full       (res_full)
    );

    // output side
    result_serializer #(.K(K), .N(N)) ser0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_load  (res_load),
        .res_full  (res_full),
        .me_result (me_result),
        .me_valid  (me_valid)
    );

endmodule

`default_nettype wire

/* hw/mont_const_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module mont_const_gen #(
    parameter int K = modexp_pkg::default_word_w,
    parameter int N = modexp_pkg::default_num_words
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             const_start,
    input  logic [K*N-1:0]   m_full,
    output logic             const_done,
    output logic [K*N-1:0]   r_mod_m,
    output logic [K*N-1:0]   r2_mod_m
);

    localparam int W  = K * N;
    localparam int CW = $clog2(2 * W);

    logic [W-1:0]  res_q;
    logic [W:0]    dbl;
    logic [W:0]    red;
    logic [CW-1:0] step_q;
    logic          busy_q;

    // residue stays below m, so one subtraction is enough after doubling
    assign dbl = {res_q, 1'b0};
    assign red = (dbl >= {1'b0, m_full}) ? dbl - {1'b0, m_full} : dbl;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q     <= 1'b0;
            step_q     <= '0;
            const_done <= 1'b0;
        end else begin
            const_done <= 1'b0;
            if (const_start) begin
                busy_q <= 1'b1;
                step_q <= '0;
            end else if (busy_q) begin
                step_q <= step_q + 1'b1;
                if (step_q == CW'(2 * W - 1)) begin
                    busy_q     <= 1'b0;
                    const_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (const_start) begin
            res_q <= W'(1);
        end else if (busy_q) begin
            res_q <= red[W-1:0];
        end
        // 2^W after w doublings, 2^2W after 2w
        if (busy_q && step_q == CW'(W - 1)) begin
            r_mod_m <= red[W-1:0];
        end
        if (busy_q && step_q == CW'(2 * W - 1)) begin
            r2_mod_m <= red[W-1:0];
        end
    end

endmodule

`default_nettype wire

/* hw/mont_mul.sv */
`timescale 1ns/1ps
`default_nettype none

module mont_mul #(
    parameter int K = modexp_pkg::default_word_w,
    parameter int N = modexp_pkg::default_num_words
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             mul_start,
    input  logic [K*N-1:0]   mul_a,
    input  logic [K*N-1:0]   mul_b,
    input  logic [K*N-1:0]   m_full,
    output logic             mul_done,
    output logic [K*N-1:0]   mul_p
);

    localparam int W  = K * N;
    localparam int CW = $clog2(W + 1);

    localparam logic [CW-1:0] last_step = CW'(W);

    logic [W-1:0]  a_q;
    logic [W-1:0]  b_q;
    // two guard bits, acc stays below 2m and the sum below 4m
    logic [W+1:0]  acc_q;
    logic [W+1:0]  sum_ab;
    logic [W+1:0]  sum_m;
    logic [W+1:0]  diff;
    logic [CW-1:0] step_q;
    logic          busy_q;

    // ---------------------------------------------------------------------
    // one radix-2 step per cycle
    // ---------------------------------------------------------------------
    always_comb begin
        sum_ab = acc_q + (a_q[0] ? {2'b00, b_q} : '0);
        // make the sum even before halving
        sum_m  = sum_ab + (sum_ab[0] ? {2'b00, m_full} : '0);
        diff   = acc_q - {2'b00, m_full};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q   <= 1'b0;
            step_q   <= '0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= 1'b0;
            if (mul_start) begin
                busy_q <= 1'b1;
                step_q <= '0;
            end else if (busy_q) begin
                if (step_q == last_step) begin
                    busy_q   <= 1'b0;
                    mul_done <= 1'b1;
                end else begin
                    step_q <= step_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            a_q   <= mul_a;
            b_q   <= mul_b;
            acc_q <= '0;
        end else if (busy_q && step_q != last_step) begin
            acc_q <= sum_m >> 1;
            a_q   <= a_q >> 1;
        end else if (busy_q) begin
            // final correction into [0, m)
            mul_p <= (acc_q >= {2'b00, m_full}) ? diff[W-1:0] : acc_q[W-1:0];
        end
    end

    // sequencer must wait for mul_done before the next operand pair
    no_start_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        mul_start |-> !busy_q)
        else $error("mont_mul: start while busy");

endmodule

`default_nettype wire

/* hw/operand_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_loader #(
    parameter int K = modexp_pkg::default_word_w,
    parameter int N = modexp_pkg::default_num_words
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             me_start,
    input  logic [K-1:0]     me_x,
    input  logic             me_x_valid,
    input  logic [K-1:0]     me_y,
    input  logic             me_y_valid,
    input  logic [K-1:0]     me_m,
    input  logic             me_m_valid,
    output logic [K*N-1:0]   x_full,
    output logic [K*N-1:0]   y_full,
    output logic [K*N-1:0]   m_full,
    output logic             operands_ready
);

    localparam int W  = K * N;
    localparam int CW = $clog2(N + 1);

    // stream 0 is x, 1 is y, 2 is m
    logic [2:0][K-1:0]  word_in;
    logic [2:0]         strobe;
    logic [2:0][CW-1:0] cnt_q;
    logic [2:0][W-1:0]  full_q;
    logic [2:0]         take;
    logic [2:0]         fin;
    logic               busy_q;

    assign word_in = {me_m, me_y, me_x};
    assign strobe  = {me_m_valid, me_y_valid, me_x_valid};

    // a stream counts as finished once its n-th word is taken this cycle
    always_comb begin
        for (int s = 0; s < 3; s++) begin
            take[s] = busy_q && strobe[s] && (cnt_q[s] != CW'(N));
            fin[s]  = (cnt_q[s] == CW'(N)) || (take[s] && (cnt_q[s] == CW'(N - 1)));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q         <= 1'b0;
            cnt_q          <= '0;
            operands_ready <= 1'b0;
        end else begin
            operands_ready <= 1'b0;
            if (!busy_q) begin
                if (me_start) begin
                    busy_q <= 1'b1;
                    cnt_q  <= '0;
                end
            end else begin
                for (int s = 0; s < 3; s++) begin
                    if (take[s]) begin
                        cnt_q[s] <= cnt_q[s] + 1'b1;
                    end
                end
                if (&fin) begin
                    busy_q         <= 1'b0;
                    operands_ready <= 1'b1;
                end
            end
        end
    end

    // new word enters at the top, so word 0 ends up lowest
    always_ff @(posedge clk) begin
        for (int s = 0; s < 3; s++) begin
            if (take[s]) begin
                full_q[s] <= (full_q[s] >> K) | (W'(word_in[s]) << (W - K));
            end
        end
    end

    assign x_full = full_q[0];
    assign y_full = full_q[1];
    assign m_full = full_q[2];

    cnt_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        (cnt_q[0] <= CW'(N)) && (cnt_q[1] <= CW'(N)) && (cnt_q[2] <= CW'(N)))
        else $error("operand_loader: word counter past N");

endmodule

`default_nettype wire

/* hw/result_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module result_serializer #(
    parameter int K = modexp_pkg::default_word_w,
    parameter int N = modexp_pkg::default_num_words
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             res_load,
    input  logic [K*N-1:0]   res_full,
    output logic [K-1:0]     me_result,
    output logic             me_valid
);

    localparam int W  = K * N;
    localparam int CW = $clog2(N + 1);

    logic [W-1:0]  shift_q;
    logic [CW-1:0] left_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left_q <= '0;
        end else if (res_load) begin
            left_q <= CW'(N);
        end else if (left_q != '0) begin
            left_q <= left_q - 1'b1;
        end
    end

    // lowest word sits at the bottom, shifted out first
    always_ff @(posedge clk) begin
        if (res_load) begin
            shift_q <= res_full;
        end else if (left_q != '0) begin
            shift_q <= shift_q >> K;
        end
    end

    assign me_result = shift_q[K-1:0];
    assign me_valid  = (left_q != '0);

    no_load_while_shifting: assert property (@(posedge clk) disable iff (!rst_n)
        res_load |-> (left_q == '0))
        else $error("result_serializer: load while words still pending");

endmodule

`default_nettype wire

/* tb.f */
+incdir+testbench
hw/modexp_pkg.sv
hw/operand_loader.sv
hw/mont_const_gen.sv
hw/mont_mul.sv
hw/modexp_sequencer.sv
hw/result_serializer.sv
hw/modexp_top.sv
testbench/tb_modexp.sv

/* testbench/modexp_model.svh */
`ifndef modexp_model_svh
`define modexp_model_svh

// lfsr state, x^32 + x^22 + x^2 + x + 1
logic [31:0] lfsr_q = 32'd69;

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one lfsr step per bit, msb first
task automatic take_bits(input int n, output logic [W-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_q = lfsr_next(lfsr_q);
        v = {v[W-2:0], lfsr_q[0]};
    end
endtask

// ----------------------------------------------------------------------
// plain modular arithmetic, no montgomery form
// ----------------------------------------------------------------------
// shift-and-add, a must be below m
function automatic logic [W-1:0] mod_mul(input logic [W-1:0] a, b, m);
    logic [2*W-1:0] r;
    r = '0;
    for (int i = W - 1; i >= 0; i--) begin
        r = r << 1;
        if (r >= m) begin
            r = r - m;
        end
        if (b[i]) begin
            r = r + a;
        end
        if (r >= m) begin
            r = r - m;
        end
    end
    return r[W-1:0];
endfunction

function automatic logic [W-1:0] mod_exp(input logic [W-1:0] x, y, m);
    logic [W-1:0] r;
    r = W'(1);
    for (int i = W - 1; i >= 0; i--) begin
        r = mod_mul(r, r, m);
        if (y[i]) begin
            r = mod_mul(r, x, m);
        end
    end
    return r;
endfunction

// odd modulus with the top bit set
task automatic gen_modulus(output logic [W-1:0] m);
    take_bits(W, m);
    m[W-1] = 1'b1;
    m[0]   = 1'b1;
endtask

// m >= 2^(W-1), so one subtraction brings x below m
task automatic gen_below(input logic [W-1:0] m, output logic [W-1:0] x);
    take_bits(W, x);
    if (x >= m) begin
        x = x - m;
    end
endtask

`endif

/* testbench/tb_modexp.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_modexp;

    import modexp_pkg::*;

    localparam int K = default_word_w;
    localparam int N = default_num_words;
    localparam int W = K * N;

    // y = 0, y = 1, all-ones y, then twenty random
    localparam int num_ops = 23;
    localparam longint watchdog_cycles = longint'(num_ops) * (2 * W + 2) * (W + 2) + 5000;

    logic         clk;
    logic         rst_n;
    logic         me_start;
    logic [K-1:0] me_x;
    logic         me_x_valid;
    logic [K-1:0] me_y;
    logic         me_y_valid;
    logic [K-1:0] me_m;
    logic         me_m_valid;
    logic [K-1:0] me_result;
    logic         me_valid;
    logic         result_due;

    `include "modexp_model.svh"

    modexp_top #(.K(K), .N(N)) dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .me_start   (me_start),
        .me_x       (me_x),
        .me_x_valid (me_x_valid),
        .me_y       (me_y),
        .me_y_valid (me_y_valid),
        .me_m       (me_m),
        .me_m_valid (me_m_valid),
        .me_result  (me_result),
        .me_valid   (me_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // error reporting and compare tasks
    // ----------------------------------------------------------------------
    task automatic report_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input logic [K-1:0] got, input int idx, input logic [K-1:0] want);
        if (got !== want) begin
            report_error($sformatf("result word %0d is %h, expected %h", idx, got, want));
        end
    endtask

    task automatic check_count(input int got);
        if (got != N) begin
            report_error($sformatf("me_valid held %0d cycles, expected %0d", got, N));
        end
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    // random interleaving and gaps, junk strobes once a stream is done
    task automatic load_operands(input logic [W-1:0] x, y, m);
        logic [W-1:0] ops [3];
        int           sent [3];
        logic [K-1:0] d [3];
        logic [W-1:0] coin;
        logic [W-1:0] junk;
        ops[0] = x;
        ops[1] = y;
        ops[2] = m;
        for (int s = 0; s < 3; s++) begin
            sent[s] = 0;
        end
        @(posedge clk);
        me_start <= 1'b1;
        @(posedge clk);
        me_start <= 1'b0;
        while (sent[0] < N || sent[1] < N || sent[2] < N) begin
            take_bits(3, coin);
            take_bits(K, junk);
            for (int s = 0; s < 3; s++) begin
                d[s] = (sent[s] < N) ? ops[s][sent[s]*K +: K] : junk[K-1:0];
                if (coin[s] && sent[s] < N) begin
                    sent[s]++;
                end
            end
            me_x       <= d[0];
            me_x_valid <= coin[0];
            me_y       <= d[1];
            me_y_valid <= coin[1];
            me_m       <= d[2];
            me_m_valid <= coin[2];
            @(posedge clk);
        end
        me_x_valid <= 1'b0;
        me_y_valid <= 1'b0;
        me_m_valid <= 1'b0;
    endtask

    // outputs settle after the rising edge, so look at them on the falling one
    task automatic collect_result(input logic [W-1:0] want);
        int idx;
        idx = 0;
        @(negedge clk);
        while (!me_valid) begin
            @(negedge clk);
        end
        while (me_valid) begin
            if (idx < N) begin
                check_word(me_result, idx, want[idx*K +: K]);
            end
            idx++;
            @(negedge clk);
        end
        check_count(idx);
    endtask

    task automatic run_op(input logic [W-1:0] x, y, m);
        logic [W-1:0] want;
        want = mod_exp(x, y, m);
        load_operands(x, y, m);
        result_due = 1'b1;
        collect_result(want);
        result_due = 1'b0;
    endtask

    // no result words unless an operation is in flight
    always @(negedge clk) begin
        if (me_valid === 1'b1 && !result_due) begin
            report_error("me_valid high with no result due");
        end
    end

    initial begin
        seq_state_e st;
        repeat (watchdog_cycles) @(posedge clk);
        st = dut0.seq0.state_q;
        $display("timeout: no result, sequencer in %s", st.name());
        $display("TEST FAILED");
        $fatal(1);
    end

    initial begin
        logic [W-1:0] x;
        logic [W-1:0] y;
        logic [W-1:0] m;
        rst_n      = 1'b0;
        me_start   = 1'b0;
        me_x       = '0;
        me_x_valid = 1'b0;
        me_y       = '0;
        me_y_valid = 1'b0;
        me_m       = '0;
        me_m_valid = 1'b0;
        result_due = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        // idle stretch, monitor watches me_valid
        repeat (20) @(posedge clk);

        gen_modulus(m);
        gen_below(m, x);
        run_op(x, '0, m);
        gen_modulus(m);
        gen_below(m, x);
        run_op(x, W'(1), m);
        // (m-1)^odd is m-1
        gen_modulus(m);
        run_op(m - 1'b1, '1, m);

        // new modulus every time
        for (int t = 0; t < num_ops - 3; t++) begin
            gen_modulus(m);
            gen_below(m, x);
            take_bits(W, y);
            run_op(x, y, m);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
